// ==== source/sort_pkg.sv ====
// Shared definitions for the streaming merge sorter:
// chunk geometry, width limits and the tag carried by each input beat
package sort_pkg;

    // Entries per chunk; the sorting network is built for exactly eight
    localparam int CHUNK_SIZE = 8;
    localparam int LANE_WIDTH = 3;
    localparam int LENGTH_WIDTH = 16;
    localparam int CHUNK_INDEX_WIDTH = 8;

    typedef struct packed {
        logic [CHUNK_INDEX_WIDTH-1:0] chunk;
        logic [LANE_WIDTH-1:0]        lane;
        // Final beat of the current chunk
        logic                         last_in_chunk;
        // Set on every beat of the final chunk of the run
        logic                         last_chunk;
    } chunk_tag_t;

endpackage

// ==== source/sort_control.sv ====
// Sort control: run length register, input beat counting and chunk tagging,
// input back-pressure and the merge start pulse
`timescale 1ns/1ns

module sort_control #(
    parameter int DATA_WIDTH = 32,
    parameter int MAX_SORT_LENGTH = 32
) (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic                                   start,
    input  logic [sort_pkg::LENGTH_WIDTH-1:0]      length,
    input  logic                                   in_valid,
    output logic                                   in_ready,
    input  logic [DATA_WIDTH-1:0]                  in_data,
    output logic                                   beat_valid,
    output logic [DATA_WIDTH-1:0]                  beat_data,
    output sort_pkg::chunk_tag_t                   beat_tag,
    input  logic                                   sorter_busy,
    input  logic                                   chunks_written,
    output logic                                   merge_start,
    output logic [sort_pkg::CHUNK_INDEX_WIDTH-1:0] chunk_total
);
    import sort_pkg::*;

    logic [LENGTH_WIDTH-1:0]      length_m1;
    logic [CHUNK_INDEX_WIDTH-1:0] last_chunk_index;
    logic [LANE_WIDTH-1:0]        last_lane;
    logic [CHUNK_INDEX_WIDTH-1:0] chunk_count;
    logic [LANE_WIDTH-1:0]        lane_count;
    logic                         active;
    logic                         in_last_chunk;
    logic                         chunk_end;

    assign length_m1 = length - 1'b1;
    assign chunk_total = last_chunk_index + 1'b1;

    assign in_last_chunk = (chunk_count == last_chunk_index);
    // A short final chunk ends at its own size rather than at lane seven
    assign chunk_end = in_last_chunk ? (lane_count == last_lane)
                                     : (lane_count == LANE_WIDTH'(CHUNK_SIZE - 1));

    assign in_ready = active && !sorter_busy;
    assign beat_valid = in_valid && in_ready;
    assign beat_data = in_data;

    assign beat_tag.chunk = chunk_count;
    assign beat_tag.lane = lane_count;
    assign beat_tag.last_in_chunk = chunk_end;
    assign beat_tag.last_chunk = in_last_chunk;

    always_ff @(posedge clock) begin
        if (rst) begin
            active <= 1'b0;
            chunk_count <= '0;
            lane_count <= '0;
            last_chunk_index <= '0;
            last_lane <= '0;
            merge_start <= 1'b0;
        end else begin
            merge_start <= chunks_written;
            if (start) begin
                // Keep the index of the final chunk and its last lane
                last_chunk_index <= CHUNK_INDEX_WIDTH'(length_m1 >> LANE_WIDTH);
                last_lane <= length_m1[LANE_WIDTH-1:0];
                chunk_count <= '0;
                lane_count <= '0;
                active <= 1'b1;
            end else if (beat_valid) begin
                if (chunk_end) begin
                    lane_count <= '0;
                    chunk_count <= chunk_count + 1'b1;
                    if (in_last_chunk) begin
                        active <= 1'b0;
                    end
                end else begin
                    lane_count <= lane_count + 1'b1;
                end
            end
        end
    end

    // The run must fit in the chunk buffer
    assert property (@(posedge clock) disable iff (rst)
        start |-> (length != '0 && length <= MAX_SORT_LENGTH));

endmodule

// ==== source/chunk_sorter.sv ====
// Chunk sorter: eight-entry Batcher odd-even merge network evaluated
// one comparator level per clock, then write-out of the real entries
`timescale 1ns/1ns

module chunk_sorter #(
    parameter int DATA_WIDTH = 32,
    parameter int MAX_SORT_LENGTH = 32
) (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic                                   beat_valid,
    input  logic [DATA_WIDTH-1:0]                  beat_data,
    input  sort_pkg::chunk_tag_t                   beat_tag,
    output logic                                   busy,
    output logic                                   wr_en,
    output logic [sort_pkg::CHUNK_INDEX_WIDTH-1:0] wr_chunk,
    output logic [sort_pkg::LANE_WIDTH-1:0]        wr_lane,
    output logic [DATA_WIDTH-1:0]                  wr_data,
    output logic                                   count_en,
    output logic [sort_pkg::LANE_WIDTH:0]          count_value,
    output logic                                   chunks_written
);
    import sort_pkg::*;

    localparam int NUM_CHUNKS = MAX_SORT_LENGTH / CHUNK_SIZE;
    localparam int LEVELS = 6;

    // Partner lane of every lane at each comparator level.
    // A lane that is its own partner passes through unchanged
    localparam logic [LANE_WIDTH-1:0] PARTNER [LEVELS][CHUNK_SIZE] = '{
        '{3'd1, 3'd0, 3'd3, 3'd2, 3'd5, 3'd4, 3'd7, 3'd6},
        '{3'd2, 3'd3, 3'd0, 3'd1, 3'd6, 3'd7, 3'd4, 3'd5},
        '{3'd0, 3'd2, 3'd1, 3'd3, 3'd4, 3'd6, 3'd5, 3'd7},
        '{3'd4, 3'd5, 3'd6, 3'd7, 3'd0, 3'd1, 3'd2, 3'd3},
        '{3'd0, 3'd1, 3'd4, 3'd5, 3'd2, 3'd3, 3'd6, 3'd7},
        '{3'd0, 3'd2, 3'd1, 3'd4, 3'd3, 3'd6, 3'd5, 3'd7}
    };

    typedef enum logic [1:0] {
        COLLECT,
        SORT,
        WRITE
    } phase_t;

    phase_t                       phase;
    logic [2:0]                   level;
    logic [LANE_WIDTH-1:0]        write_lane;
    logic [LANE_WIDTH:0]          entry_count;
    logic [CHUNK_INDEX_WIDTH-1:0] chunk;
    logic                         last_chunk;
    logic                         last_write;
    logic [LANE_WIDTH-1:0]        partner [CHUNK_SIZE];
    logic [DATA_WIDTH-1:0]        entries [CHUNK_SIZE];
    logic [DATA_WIDTH-1:0]        other [CHUNK_SIZE];
    logic [DATA_WIDTH-1:0]        level_out [CHUNK_SIZE];

    assign partner = PARTNER[level];

    // The lower lane of a pair keeps the minimum and the upper lane the maximum
    always_comb begin
        for (int i = 0; i < CHUNK_SIZE; i++) begin
            other[i] = entries[partner[i]];
            if ((i < int'(partner[i])) == (other[i] < entries[i])) begin
                level_out[i] = other[i];
            end else begin
                level_out[i] = entries[i];
            end
        end
    end

    assign busy = (phase != COLLECT);
    assign wr_en = (phase == WRITE);
    assign wr_chunk = chunk;
    assign wr_lane = write_lane;
    assign wr_data = entries[write_lane];
    assign last_write = wr_en && ({1'b0, write_lane} == entry_count - 1'b1);
    assign count_en = last_write;
    assign count_value = entry_count;

    always_ff @(posedge clock) begin
        if (rst) begin
            phase <= COLLECT;
            level <= '0;
            write_lane <= '0;
            chunks_written <= 1'b0;
        end else begin
            chunks_written <= 1'b0;
            case (phase)
                COLLECT: begin
                    if (beat_valid && beat_tag.last_in_chunk) begin
                        phase <= SORT;
                    end
                end
                SORT: begin
                    if (level == 3'(LEVELS - 1)) begin
                        level <= '0;
                        phase <= WRITE;
                    end else begin
                        level <= level + 1'b1;
                    end
                end
                WRITE: begin
                    if (last_write) begin
                        write_lane <= '0;
                        phase <= COLLECT;
                        chunks_written <= last_chunk;
                    end else begin
                        write_lane <= write_lane + 1'b1;
                    end
                end
                default: phase <= COLLECT;
            endcase
        end
    end

    // Entry registers and the chunk bookkeeping captured with the closing beat
    always_ff @(posedge clock) begin
        if (phase == SORT) begin
            entries <= level_out;
        end else if (beat_valid) begin
            for (int i = 0; i < CHUNK_SIZE; i++) begin
                if (LANE_WIDTH'(i) == beat_tag.lane) begin
                    entries[i] <= beat_data;
                end else if (beat_tag.last_in_chunk && LANE_WIDTH'(i) > beat_tag.lane) begin
                    // Unfilled lanes of a short chunk sort to the top as all ones
                    entries[i] <= '1;
                end
            end
        end
        if (beat_valid && beat_tag.last_in_chunk) begin
            chunk <= beat_tag.chunk;
            entry_count <= {1'b0, beat_tag.lane} + 1'b1;
            last_chunk <= beat_tag.last_chunk;
        end
    end

    // Control holds input back while the network runs
    assert property (@(posedge clock) disable iff (rst)
        beat_valid |-> (!busy && beat_tag.chunk < NUM_CHUNKS));

endmodule

// ==== source/chunk_buffer.sv ====
// Chunk buffer: register array for all sorted chunks, the real entry
// count of each chunk and one combinational read port per merge head
`timescale 1ns/1ns

module chunk_buffer #(
    parameter int DATA_WIDTH = 32,
    parameter int MAX_SORT_LENGTH = 32
) (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic                                   wr_en,
    input  logic [sort_pkg::CHUNK_INDEX_WIDTH-1:0] wr_chunk,
    input  logic [sort_pkg::LANE_WIDTH-1:0]        wr_lane,
    input  logic [DATA_WIDTH-1:0]                  wr_data,
    input  logic                                   count_en,
    input  logic [sort_pkg::LANE_WIDTH:0]          count_value,
    input  logic [sort_pkg::CHUNK_INDEX_WIDTH-1:0] rd_chunk [MAX_SORT_LENGTH / sort_pkg::CHUNK_SIZE],
    input  logic [sort_pkg::LANE_WIDTH-1:0]        rd_offset [MAX_SORT_LENGTH / sort_pkg::CHUNK_SIZE],
    output logic [DATA_WIDTH-1:0]                  rd_data [MAX_SORT_LENGTH / sort_pkg::CHUNK_SIZE],
    output logic [sort_pkg::LANE_WIDTH:0]          chunk_count [MAX_SORT_LENGTH / sort_pkg::CHUNK_SIZE]
);
    import sort_pkg::*;

    localparam int NUM_CHUNKS = MAX_SORT_LENGTH / CHUNK_SIZE;
    localparam int ADDR_WIDTH = $clog2(MAX_SORT_LENGTH);

    logic [DATA_WIDTH-1:0] mem [MAX_SORT_LENGTH];
    logic [LANE_WIDTH:0]   counts [NUM_CHUNKS];

    // Chunk number above the lane gives the word address
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[ADDR_WIDTH'({wr_chunk, wr_lane})] <= wr_data;
        end
    end

    always_ff @(posedge clock) begin
        for (int c = 0; c < NUM_CHUNKS; c++) begin
            if (rst) begin
                counts[c] <= '0;
            end else if (count_en && wr_chunk == CHUNK_INDEX_WIDTH'(c)) begin
                counts[c] <= count_value;
            end
        end
    end

    always_comb begin
        for (int c = 0; c < NUM_CHUNKS; c++) begin
            rd_data[c] = mem[ADDR_WIDTH'({rd_chunk[c], rd_offset[c]})];
        end
    end

    assign chunk_count = counts;

endmodule

// ==== source/merge_unit.sv ====
// Merge unit: multi-way merge over the chunk heads, registered output
// stream with back-pressure and the done pulse
`timescale 1ns/1ns

module merge_unit #(
    parameter int DATA_WIDTH = 32,
    parameter int MAX_SORT_LENGTH = 32
) (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic                                   merge_start,
    input  logic [sort_pkg::CHUNK_INDEX_WIDTH-1:0] chunk_total,
    output logic [sort_pkg::LANE_WIDTH-1:0]        rd_offset [MAX_SORT_LENGTH / sort_pkg::CHUNK_SIZE],
    input  logic [DATA_WIDTH-1:0]                  rd_data [MAX_SORT_LENGTH / sort_pkg::CHUNK_SIZE],
    input  logic [sort_pkg::LANE_WIDTH:0]          chunk_count [MAX_SORT_LENGTH / sort_pkg::CHUNK_SIZE],
    output logic [DATA_WIDTH-1:0]                  out_data,
    output logic                                   out_valid,
    input  logic                                   out_ready,
    output logic                                   done
);
    import sort_pkg::*;

    localparam int NUM_CHUNKS = MAX_SORT_LENGTH / CHUNK_SIZE;

    logic [LANE_WIDTH:0]          head [NUM_CHUNKS];
    logic [CHUNK_INDEX_WIDTH-1:0] total;
    logic [CHUNK_INDEX_WIDTH-1:0] total_now;
    logic                         running;
    logic                         load;
    logic                         found;
    logic [DATA_WIDTH-1:0]        best;
    logic [NUM_CHUNKS-1:0]        avail;
    logic [NUM_CHUNKS-1:0]        win;

    // On the start cycle the chunk total comes straight from the port
    assign total_now = merge_start ? chunk_total : total;

    // The output register takes a new value when empty or being drained
    assign load = (running || merge_start) && (!out_valid || out_ready);

    always_comb begin
        for (int c = 0; c < NUM_CHUNKS; c++) begin
            rd_offset[c] = head[c][LANE_WIDTH-1:0];
            avail[c] = (CHUNK_INDEX_WIDTH'(c) < total_now) && (head[c] < chunk_count[c]);
        end
    end

    // Smallest live head; the strict compare lets the lower chunk win a tie
    always_comb begin
        int pick;
        pick = 0;
        found = 1'b0;
        best = '0;
        for (int c = 0; c < NUM_CHUNKS; c++) begin
            if (avail[c] && (!found || rd_data[c] < best)) begin
                best = rd_data[c];
                pick = c;
                found = 1'b1;
            end
        end
        win = '0;
        if (found) begin
            win[pick] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            running <= 1'b0;
            out_valid <= 1'b0;
            done <= 1'b0;
            total <= '0;
            for (int c = 0; c < NUM_CHUNKS; c++) begin
                head[c] <= '0;
            end
        end else begin
            done <= 1'b0;
            if (merge_start) begin
                total <= chunk_total;
                running <= 1'b1;
            end
            if (load) begin
                if (found) begin
                    out_valid <= 1'b1;
                    for (int c = 0; c < NUM_CHUNKS; c++) begin
                        if (win[c]) begin
                            head[c] <= head[c] + 1'b1;
                        end
                    end
                end else begin
                    // All chunks drained and the final beat just left
                    out_valid <= 1'b0;
                    running <= 1'b0;
                    done <= out_valid;
                    for (int c = 0; c < NUM_CHUNKS; c++) begin
                        head[c] <= '0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load && found) begin
            out_data <= best;
        end
    end

    // A stalled beat stays put until the consumer takes it
    assert property (@(posedge clock) disable iff (rst)
        (out_valid && !out_ready) |=> $stable(out_data));

endmodule

// ==== source/merge_sorter.sv ====
// Streaming merge sorter top level: sort control, chunk sorter,
// chunk buffer and merge unit
`timescale 1ns/1ns

module merge_sorter #(
    parameter int DATA_WIDTH = 32,
    parameter int MAX_SORT_LENGTH = 32
) (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              start,
    input  logic [sort_pkg::LENGTH_WIDTH-1:0] length,
    input  logic [DATA_WIDTH-1:0]             in_data,
    input  logic                              in_valid,
    output logic                              in_ready,
    output logic [DATA_WIDTH-1:0]             out_data,
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic                              done
);
    import sort_pkg::*;

    localparam int NUM_CHUNKS = MAX_SORT_LENGTH / CHUNK_SIZE;

    logic                         beat_valid;
    logic [DATA_WIDTH-1:0]        beat_data;
    chunk_tag_t                   beat_tag;
    logic                         sorter_busy;
    logic                         chunks_written;
    logic                         merge_start;
    logic [CHUNK_INDEX_WIDTH-1:0] chunk_total;
    logic                         wr_en;
    logic [CHUNK_INDEX_WIDTH-1:0] wr_chunk;
    logic [LANE_WIDTH-1:0]        wr_lane;
    logic [DATA_WIDTH-1:0]        wr_data;
    logic                         count_en;
    logic [LANE_WIDTH:0]          count_value;
    logic [CHUNK_INDEX_WIDTH-1:0] rd_chunk [NUM_CHUNKS];
    logic [LANE_WIDTH-1:0]        rd_offset [NUM_CHUNKS];
    logic [DATA_WIDTH-1:0]        rd_data [NUM_CHUNKS];
    logic [LANE_WIDTH:0]          chunk_count [NUM_CHUNKS];

    // Each merge head reads from its own chunk
    for (genvar c = 0; c < NUM_CHUNKS; c++) begin : g_head
        assign rd_chunk[c] = CHUNK_INDEX_WIDTH'(c);
    end

    sort_control #(
        .DATA_WIDTH(DATA_WIDTH),
        .MAX_SORT_LENGTH(MAX_SORT_LENGTH)
    ) control_i (
        .clock(clock),
        .rst(rst),
        .start(start),
        .length(length),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_data),
        .beat_valid(beat_valid),
        .beat_data(beat_data),
        .beat_tag(beat_tag),
        .sorter_busy(sorter_busy),
        .chunks_written(chunks_written),
        .merge_start(merge_start),
        .chunk_total(chunk_total)
    );

    chunk_sorter #(
        .DATA_WIDTH(DATA_WIDTH),
        .MAX_SORT_LENGTH(MAX_SORT_LENGTH)
    ) sorter_i (
        .clock(clock),
        .rst(rst),
        .beat_valid(beat_valid),
        .beat_data(beat_data),
        .beat_tag(beat_tag),
        .busy(sorter_busy),
        .wr_en(wr_en),
        .wr_chunk(wr_chunk),
        .wr_lane(wr_lane),
        .wr_data(wr_data),
        .count_en(count_en),
        .count_value(count_value),
        .chunks_written(chunks_written)
    );

    chunk_buffer #(
        .DATA_WIDTH(DATA_WIDTH),
        .MAX_SORT_LENGTH(MAX_SORT_LENGTH)
    ) buffer_i (
        .clock(clock),
        .rst(rst),
        .wr_en(wr_en),
        .wr_chunk(wr_chunk),
        .wr_lane(wr_lane),
        .wr_data(wr_data),
        .count_en(count_en),
        .count_value(count_value),
        .rd_chunk(rd_chunk),
        .rd_offset(rd_offset),
        .rd_data(rd_data),
        .chunk_count(chunk_count)
    );

    merge_unit #(
        .DATA_WIDTH(DATA_WIDTH),
        .MAX_SORT_LENGTH(MAX_SORT_LENGTH)
    ) merger_i (
        .clock(clock),
        .rst(rst),
        .merge_start(merge_start),
        .chunk_total(chunk_total),
        .rd_offset(rd_offset),
        .rd_data(rd_data),
        .chunk_count(chunk_count),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .done(done)
    );

endmodule

// ==== test/merge_sorter_tb.sv ====
// Directed testbench for the streaming merge sorter
// LFSR stimulus, reference sort of each run, data and done checks
`timescale 1ns/1ns

module merge_sorter_tb;
    import sort_pkg::*;

    localparam int DATA_WIDTH = 32;
    localparam int WAIT_LIMIT = 200;
    localparam logic [31:0] SEED = 32'h332e_c0ca;

    logic                    clock;
    logic                    rst;
    logic                    start;
    logic [LENGTH_WIDTH-1:0] length;
    logic [DATA_WIDTH-1:0]   in_data;
    logic                    in_valid;
    logic                    in_ready;
    logic [DATA_WIDTH-1:0]   out_data;
    logic                    out_valid;
    logic                    out_ready;
    logic                    done;

    logic [31:0]           lfsr_state;
    logic [DATA_WIDTH-1:0] stimulus [$];
    logic [DATA_WIDTH-1:0] sorted_ref [$];
    logic                  timed_out;
    int                    data_errors;
    int                    bit_errors;
    int                    protocol_errors;
    int                    timeouts;

    merge_sorter dut_i (
        .clock(clock),
        .rst(rst),
        .start(start),
        .length(length),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .done(done)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL time %0t: %s expected %h got %h", $time, name, expected, actual);
            data_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL time %0t: %s expected %b got %b", $time, name, expected, actual);
            bit_errors++;
        end
    endtask

    // Called on a rising edge; each beat moves on the edge after in_ready is seen
    task automatic send_values();
        int waited;
        foreach (stimulus[i]) begin
            in_valid <= 1'b1;
            in_data <= stimulus[i];
            waited = 0;
            @(negedge clock);
            while (!in_ready) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    $display("Timeout: in_ready never rose for input beat %0d", i);
                    timeouts++;
                    timed_out = 1'b1;
                    return;
                end
                @(negedge clock);
            end
            @(posedge clock);
        end
        in_valid <= 1'b0;
    endtask

    task automatic collect_values(input bit stall);
        int                    count;
        int                    idle;
        logic                  held;
        logic [DATA_WIDTH-1:0] held_value;
        logic [31:0]           ready_bits;
        count = 0;
        idle = 0;
        held = 1'b0;
        while (count < sorted_ref.size()) begin
            @(posedge clock);
            if (stall) begin
                ready_bits = take_bits(1);
                out_ready <= ready_bits[0];
            end else begin
                out_ready <= 1'b1;
            end
            @(negedge clock);
            check_bit("done", 1'b0, done);
            if (held) begin
                if (out_valid) begin
                    check_data("out_data (stalled)", held_value, out_data);
                end else begin
                    $display("out_valid dropped while output beat %0d was stalled", count);
                    protocol_errors++;
                end
            end
            held = 1'b0;
            if (out_valid && out_ready) begin
                check_data("out_data", sorted_ref[count], out_data);
                count++;
                idle = 0;
            end else begin
                if (out_valid) begin
                    held = 1'b1;
                    held_value = out_data;
                end
                idle++;
                if (idle > WAIT_LIMIT) begin
                    $display("Timeout: output beat %0d was never transferred", count);
                    timeouts++;
                    timed_out = 1'b1;
                    return;
                end
            end
        end
    endtask

    // Done must be a single pulse with no beat left behind it
    task automatic wait_for_done();
        int waited;
        waited = 0;
        @(negedge clock);
        while (!done) begin
            if (out_valid) begin
                $display("Extra output beat %h appeared after the last expected value",
                         out_data);
                protocol_errors++;
            end
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: done never pulsed after the last output beat");
                timeouts++;
                timed_out = 1'b1;
                return;
            end
            @(negedge clock);
        end
        check_bit("out_valid", 1'b0, out_valid);
        @(negedge clock);
        check_bit("done", 1'b0, done);
    endtask

    task automatic run_sort(input bit stall);
        sorted_ref = stimulus;
        sorted_ref.sort();
        // Between runs the sorter takes no input and offers no output
        @(negedge clock);
        check_bit("in_ready", 1'b0, in_ready);
        check_bit("out_valid", 1'b0, out_valid);
        @(posedge clock);
        start <= 1'b1;
        length <= LENGTH_WIDTH'(stimulus.size());
        @(posedge clock);
        start <= 1'b0;
        send_values();
        if (timed_out) return;
        collect_values(stall);
        if (timed_out) return;
        wait_for_done();
    endtask

    task automatic random_values(input int count);
        stimulus.delete();
        repeat (count) stimulus.push_back(DATA_WIDTH'(take_bits(DATA_WIDTH)));
    endtask

    task automatic full_length_run();
        random_values(32);
        run_sort(1'b0);
    endtask

    // Padding of the short second chunk must never reach the output
    task automatic partial_last_chunk();
        random_values(13);
        run_sort(1'b0);
    endtask

    task automatic short_runs();
        random_values(5);
        run_sort(1'b0);
        if (timed_out) return;
        random_values(1);
        run_sort(1'b0);
    endtask

    task automatic duplicates_and_extremes();
        stimulus.delete();
        for (int i = 0; i < 24; i++) begin
            case (i % 4)
                0: stimulus.push_back({DATA_WIDTH{1'b0}});
                1: stimulus.push_back({DATA_WIDTH{1'b1}});
                2: stimulus.push_back(DATA_WIDTH'(32'h0000_0100));
                default: stimulus.push_back(DATA_WIDTH'(take_bits(3)));
            endcase
        end
        run_sort(1'b0);
    endtask

    task automatic output_backpressure();
        random_values(32);
        run_sort(1'b1);
    endtask

    task automatic back_to_back_runs();
        random_values(20);
        run_sort(1'b0);
        if (timed_out) return;
        random_values(7);
        run_sort(1'b0);
    endtask

    initial begin
        lfsr_state = SEED;
        timed_out = 1'b0;
        data_errors = 0;
        bit_errors = 0;
        protocol_errors = 0;
        timeouts = 0;
        rst <= 1'b1;
        start <= 1'b0;
        length <= '0;
        in_data <= '0;
        in_valid <= 1'b0;
        out_ready <= 1'b0;
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        if (!timed_out) full_length_run();
        if (!timed_out) partial_last_chunk();
        if (!timed_out) short_runs();
        if (!timed_out) duplicates_and_extremes();
        if (!timed_out) output_backpressure();
        if (!timed_out) back_to_back_runs();
        $display("Errors: data %0d, bit %0d, protocol %0d, timeout %0d",
                 data_errors, bit_errors, protocol_errors, timeouts);
        if (data_errors + bit_errors + protocol_errors + timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/sort_pkg.sv
source/sort_control.sv
source/chunk_sorter.sv
source/chunk_buffer.sv
source/merge_unit.sv
source/merge_sorter.sv
test/merge_sorter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the merge sorter testbench with Verilator and run it.
# Exits 0 only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 \
    --top-module merge_sorter_tb \
    -f verilog.f \
    -o merge_sorter_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/merge_sorter_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
